// ==== lrelu_params_pkg.sv ====
package lrelu_params_pkg;

  // lanes of one data beat
  localparam int GROUPS  = 2;
  localparam int UNITS   = 4;

  // base table depth, one entry per member
  localparam int MEMBERS = 2;

  // table depth per kernel mode
  localparam int DEPTH_3X3 = MEMBERS;
  localparam int DEPTH_1X1 = 3 * MEMBERS;

  // address sized for the deeper table
  localparam int ADDR_BITS = $clog2(DEPTH_1X1);

  // word widths
  localparam int ACC_BITS  = 16;
  localparam int OUT_BITS  = 8;
  localparam int COEF_BITS = 16;
  localparam int WIDE_BITS = 32;

  // A is a Q8 scale
  localparam int SCALE_SHIFT = 8;

  // leaky slope, 13/128 is close to 0.1
  localparam int ALPHA_NUM   = 13;
  localparam int ALPHA_SHIFT = 7;

  // signed 8-bit output range
  localparam int OUT_MAX = (2 ** (OUT_BITS - 1)) - 1;
  localparam int OUT_MIN = -(2 ** (OUT_BITS - 1));

endpackage

// ==== lrelu_stream_pkg.sv ====
package lrelu_stream_pkg;

  // plain words
  typedef logic signed [lrelu_params_pkg::ACC_BITS-1:0]  acc_t;
  typedef logic signed [lrelu_params_pkg::COEF_BITS-1:0] coef_t;
  typedef logic signed [lrelu_params_pkg::OUT_BITS-1:0]  out_t;
  typedef logic signed [lrelu_params_pkg::WIDE_BITS-1:0] wide_t;
  typedef logic        [lrelu_params_pkg::ADDR_BITS-1:0] addr_t;

  typedef enum logic {
    MODE_3X3 = 1'b0,
    MODE_1X1 = 1'b1
  } kernel_mode_e;

  // loader sequence is D, then A table, then B table
  typedef enum logic [1:0] {
    LOAD_D = 2'd0,
    LOAD_A = 2'd1,
    LOAD_B = 2'd2,
    READY  = 2'd3
  } load_state_e;

  // mode is only looked at on D beats
  typedef struct packed {
    coef_t [lrelu_params_pkg::GROUPS-1:0] word;
    kernel_mode_e                         mode;
  } cfg_beat_t;

  typedef struct packed {
    acc_t [lrelu_params_pkg::GROUPS-1:0][lrelu_params_pkg::UNITS-1:0] lane;
    logic                                                             is_lrelu;
  } data_beat_t;

  // one A/B pair per group
  typedef struct packed {
    coef_t [lrelu_params_pkg::GROUPS-1:0] a;
    coef_t [lrelu_params_pkg::GROUPS-1:0] b;
  } coef_pair_t;

  typedef struct packed {
    wide_t [lrelu_params_pkg::GROUPS-1:0][lrelu_params_pkg::UNITS-1:0] lane;
    logic                                                              is_lrelu;
  } math_beat_t;

  typedef struct packed {
    out_t [lrelu_params_pkg::GROUPS-1:0][lrelu_params_pkg::UNITS-1:0] lane;
    logic                                                             is_lrelu;
  } out_beat_t;

endpackage

// ==== lrelu_coef_store.sv ====
`timescale 1ns/1ns

module lrelu_coef_store (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                cfg_valid,
  output logic                                cfg_ready,
  input  lrelu_stream_pkg::cfg_beat_t         cfg,
  input  logic                                pipe_empty,
  input  logic                                s_valid,
  output logic                                s_ready,
  input  lrelu_stream_pkg::data_beat_t        s_data,
  output logic                                beat_valid,
  input  logic                                beat_ready,
  output lrelu_stream_pkg::data_beat_t        beat,
  output lrelu_stream_pkg::coef_pair_t        coef,
  output lrelu_stream_pkg::coef_t [lrelu_params_pkg::GROUPS-1:0] d_offset
);

  lrelu_stream_pkg::load_state_e  state;
  lrelu_stream_pkg::kernel_mode_e mode_q;
  lrelu_stream_pkg::coef_t [lrelu_params_pkg::GROUPS-1:0] d_q;

  // scale and bias tables, sized for 1x1 kernels
  lrelu_stream_pkg::coef_t a_mem [lrelu_params_pkg::GROUPS][lrelu_params_pkg::DEPTH_1X1];
  lrelu_stream_pkg::coef_t b_mem [lrelu_params_pkg::GROUPS][lrelu_params_pkg::DEPTH_1X1];

  lrelu_stream_pkg::addr_t wr_addr;
  lrelu_stream_pkg::addr_t rd_ptr;
  lrelu_stream_pkg::addr_t depth_last;

  logic cfg_fire;
  logic data_fire;
  logic in_ready_state;

  // last table index for the current mode
  assign depth_last = (mode_q == lrelu_stream_pkg::MODE_1X1) ?
                      lrelu_stream_pkg::addr_t'(lrelu_params_pkg::DEPTH_1X1 - 1) :
                      lrelu_stream_pkg::addr_t'(lrelu_params_pkg::DEPTH_3X3 - 1);

  assign in_ready_state = (state == lrelu_stream_pkg::READY);

  // a reload waits until nothing is left in flight
  assign cfg_ready = !in_ready_state || pipe_empty;
  assign cfg_fire  = cfg_valid && cfg_ready;

  // data is held back while a config beat is pending
  assign beat_valid = s_valid && in_ready_state && !cfg_valid;
  assign s_ready    = in_ready_state && !cfg_valid && beat_ready;
  assign data_fire  = s_valid && s_ready;

  assign beat     = s_data;
  assign d_offset = d_q;

  always_comb begin
    for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
      coef.a[g] = a_mem[g][rd_ptr];
      coef.b[g] = b_mem[g][rd_ptr];
    end
  end

  // loader FSM and table writes
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= lrelu_stream_pkg::LOAD_D;
      mode_q  <= lrelu_stream_pkg::MODE_3X3;
      d_q     <= '0;
      wr_addr <= '0;
      for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
        for (int k = 0; k < lrelu_params_pkg::DEPTH_1X1; k++) begin
          a_mem[g][k] <= '0;
          b_mem[g][k] <= '0;
        end
      end
    end else if (cfg_fire) begin
      case (state)
        lrelu_stream_pkg::LOAD_A: begin
          for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
            a_mem[g][wr_addr] <= cfg.word[g];
          end
          if (wr_addr == depth_last) begin
            wr_addr <= '0;
            state   <= lrelu_stream_pkg::LOAD_B;
          end else begin
            wr_addr <= wr_addr + lrelu_stream_pkg::addr_t'(1);
          end
        end
        lrelu_stream_pkg::LOAD_B: begin
          for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
            b_mem[g][wr_addr] <= cfg.word[g];
          end
          if (wr_addr == depth_last) begin
            wr_addr <= '0;
            state   <= lrelu_stream_pkg::READY;
          end else begin
            wr_addr <= wr_addr + lrelu_stream_pkg::addr_t'(1);
          end
        end
        // LOAD_D, or a new D beat arriving in READY
        default: begin
          d_q     <= cfg.word;
          mode_q  <= cfg.mode;
          wr_addr <= '0;
          state   <= lrelu_stream_pkg::LOAD_A;
        end
      endcase
    end
  end

  // cyclic read pointer, restarted when a load completes
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (cfg_fire && state == lrelu_stream_pkg::LOAD_B && wr_addr == depth_last) begin
      rd_ptr <= '0;
    end else if (data_fire) begin
      if (rd_ptr == depth_last) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + lrelu_stream_pkg::addr_t'(1);
      end
    end
  end

endmodule

// ==== lrelu_lane_math.sv ====
`timescale 1ns/1ns

module lrelu_lane_math (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  lrelu_stream_pkg::data_beat_t in_beat,
  input  lrelu_stream_pkg::coef_pair_t in_coef,
  output logic                         out_valid,
  input  logic                         out_ready,
  output lrelu_stream_pkg::math_beat_t out_beat,
  output logic                         busy
);

  // stage 1 holds x*A >>> SCALE_SHIFT and the bias for stage 2
  logic v1;
  logic flag1;
  lrelu_stream_pkg::wide_t [lrelu_params_pkg::GROUPS-1:0][lrelu_params_pkg::UNITS-1:0] prod1;
  lrelu_stream_pkg::coef_t [lrelu_params_pkg::GROUPS-1:0] b1;

  // stage 2 is the outgoing math beat
  logic v2;
  lrelu_stream_pkg::math_beat_t beat2;

  logic ready1;

  lrelu_stream_pkg::wide_t [lrelu_params_pkg::GROUPS-1:0][lrelu_params_pkg::UNITS-1:0] scaled;
  lrelu_stream_pkg::wide_t [lrelu_params_pkg::GROUPS-1:0][lrelu_params_pkg::UNITS-1:0] biased;

  function automatic lrelu_stream_pkg::wide_t leaky(input lrelu_stream_pkg::wide_t y,
                                                    input logic flag);
    if (flag && y < 0) begin
      return (y * lrelu_params_pkg::ALPHA_NUM) >>> lrelu_params_pkg::ALPHA_SHIFT;
    end
    return y;
  endfunction

  assign ready1   = !v2 || out_ready;
  assign in_ready = !v1 || ready1;

  always_comb begin
    for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
      for (int u = 0; u < lrelu_params_pkg::UNITS; u++) begin
        scaled[g][u] = (lrelu_stream_pkg::wide_t'(in_beat.lane[g][u]) *
                        lrelu_stream_pkg::wide_t'(in_coef.a[g])) >>>
                       lrelu_params_pkg::SCALE_SHIFT;
        biased[g][u] = prod1[g][u] + lrelu_stream_pkg::wide_t'(b1[g]);
      end
    end
  end

  // stage 1
  always_ff @(posedge clk) begin
    if (rst) begin
      v1 <= 1'b0;
    end else if (in_ready) begin
      v1 <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && in_valid) begin
      prod1 <= scaled;
      b1    <= in_coef.b;
      flag1 <= in_beat.is_lrelu;
    end
  end

  // stage 2, bias then leaky slope
  always_ff @(posedge clk) begin
    if (rst) begin
      v2 <= 1'b0;
    end else if (ready1) begin
      v2 <= v1;
    end
  end

  always_ff @(posedge clk) begin
    if (ready1 && v1) begin
      for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
        for (int u = 0; u < lrelu_params_pkg::UNITS; u++) begin
          beat2.lane[g][u] <= leaky(biased[g][u], flag1);
        end
      end
      beat2.is_lrelu <= flag1;
    end
  end

  assign out_valid = v2;
  assign out_beat  = beat2;
  assign busy      = v1 || v2;

endmodule

// ==== lrelu_requant.sv ====
`timescale 1ns/1ns

module lrelu_requant (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  lrelu_stream_pkg::math_beat_t in_beat,
  input  lrelu_stream_pkg::coef_t [lrelu_params_pkg::GROUPS-1:0] d_offset,
  output logic                         m_valid,
  input  logic                         m_ready,
  output lrelu_stream_pkg::out_beat_t  m_data,
  output logic                         busy
);

  logic                        out_v;
  lrelu_stream_pkg::out_beat_t out_q;
  lrelu_stream_pkg::out_beat_t sat_beat;

  // clamp to the signed 8-bit range
  function automatic lrelu_stream_pkg::out_t saturate(input lrelu_stream_pkg::wide_t v);
    if (v > lrelu_params_pkg::OUT_MAX) begin
      return lrelu_stream_pkg::out_t'(lrelu_params_pkg::OUT_MAX);
    end
    if (v < lrelu_params_pkg::OUT_MIN) begin
      return lrelu_stream_pkg::out_t'(lrelu_params_pkg::OUT_MIN);
    end
    return lrelu_stream_pkg::out_t'(v);
  endfunction

  // add D per group, then clamp
  always_comb begin
    for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
      for (int u = 0; u < lrelu_params_pkg::UNITS; u++) begin
        sat_beat.lane[g][u] = saturate(in_beat.lane[g][u] +
                                       lrelu_stream_pkg::wide_t'(d_offset[g]));
      end
    end
    sat_beat.is_lrelu = in_beat.is_lrelu;
  end

  assign in_ready = !out_v || m_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_v <= 1'b0;
    end else if (in_ready) begin
      out_v <= in_valid;
    end
  end

  // output register payload
  always_ff @(posedge clk) begin
    if (in_ready && in_valid) begin
      out_q <= sat_beat;
    end
  end

  assign m_valid = out_v;
  assign m_data  = out_q;
  assign busy    = out_v;

endmodule

// ==== lrelu_engine.sv ====
`timescale 1ns/1ns

module lrelu_engine (
  input  logic                         clk,
  input  logic                         rst,

  // configuration stream
  input  logic                         cfg_valid,
  output logic                         cfg_ready,
  input  lrelu_stream_pkg::cfg_beat_t  cfg,

  // input data stream
  input  logic                         s_valid,
  output logic                         s_ready,
  input  lrelu_stream_pkg::data_beat_t s_data,

  // output stream
  output logic                         m_valid,
  input  logic                         m_ready,
  output lrelu_stream_pkg::out_beat_t  m_data
);

  // decode to execute
  logic                         dec_valid;
  logic                         dec_ready;
  lrelu_stream_pkg::data_beat_t dec_beat;
  lrelu_stream_pkg::coef_pair_t dec_coef;

  // execute to result
  logic                         ex_valid;
  logic                         ex_ready;
  lrelu_stream_pkg::math_beat_t ex_beat;

  lrelu_stream_pkg::coef_t [lrelu_params_pkg::GROUPS-1:0] d_offset;

  logic math_busy;
  logic requant_busy;
  logic pipe_empty;

  // config only proceeds in READY once the pipeline has drained
  assign pipe_empty = !(math_busy || requant_busy);

  lrelu_coef_store u_coef_store (
    .clk        (clk),
    .rst        (rst),
    .cfg_valid  (cfg_valid),
    .cfg_ready  (cfg_ready),
    .cfg        (cfg),
    .pipe_empty (pipe_empty),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_data     (s_data),
    .beat_valid (dec_valid),
    .beat_ready (dec_ready),
    .beat       (dec_beat),
    .coef       (dec_coef),
    .d_offset   (d_offset)
  );

  lrelu_lane_math u_lane_math (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (dec_valid),
    .in_ready  (dec_ready),
    .in_beat   (dec_beat),
    .in_coef   (dec_coef),
    .out_valid (ex_valid),
    .out_ready (ex_ready),
    .out_beat  (ex_beat),
    .busy      (math_busy)
  );

  lrelu_requant u_requant (
    .clk      (clk),
    .rst      (rst),
    .in_valid (ex_valid),
    .in_ready (ex_ready),
    .in_beat  (ex_beat),
    .d_offset (d_offset),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .m_data   (m_data),
    .busy     (requant_busy)
  );

endmodule

// ==== lrelu_engine_asserts.sv ====
`timescale 1ns/1ns

module lrelu_engine_asserts (
  input logic                        clk,
  input logic                        rst,
  input logic                        cfg_valid,
  input logic                        cfg_ready,
  input logic                        s_valid,
  input logic                        s_ready,
  input logic                        m_valid,
  input logic                        m_ready,
  input lrelu_stream_pkg::out_beat_t m_data
);

  // output beat holds until taken
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data)))
    else $error("m_valid or m_data changed while m_ready was low");

  a_rst_idle: assert property (@(posedge clk) rst |=> !m_valid)
    else $error("m_valid high during reset");

  // a pending config beat blocks data
  a_cfg_blocks: assert property (@(posedge clk) disable iff (rst)
    !(s_ready && cfg_valid))
    else $error("s_ready high while cfg_valid was pending");

  a_one_fire: assert property (@(posedge clk) disable iff (rst)
    !(cfg_valid && cfg_ready && s_valid && s_ready))
    else $error("config and data handshakes in the same cycle");

endmodule

bind lrelu_engine lrelu_engine_asserts asserts_i (
  .clk       (clk),
  .rst       (rst),
  .cfg_valid (cfg_valid),
  .cfg_ready (cfg_ready),
  .s_valid   (s_valid),
  .s_ready   (s_ready),
  .m_valid   (m_valid),
  .m_ready   (m_ready),
  .m_data    (m_data)
);

// ==== lrelu_engine_tb.sv ====
`timescale 1ns/1ns

module lrelu_engine_tb;

  localparam int WAIT_LIMIT = 200;

  logic clk = 1'b0;
  logic rst;
  logic cfg_valid;
  logic cfg_ready;
  lrelu_stream_pkg::cfg_beat_t cfg;
  logic s_valid;
  logic s_ready;
  lrelu_stream_pkg::data_beat_t s_data;
  logic m_valid;
  logic m_ready = 1'b1;
  lrelu_stream_pkg::out_beat_t m_data;

  // testbench copy of the coefficient state
  lrelu_stream_pkg::coef_t tb_a [lrelu_params_pkg::GROUPS][lrelu_params_pkg::DEPTH_1X1];
  lrelu_stream_pkg::coef_t tb_b [lrelu_params_pkg::GROUPS][lrelu_params_pkg::DEPTH_1X1];
  lrelu_stream_pkg::coef_t [lrelu_params_pkg::GROUPS-1:0] tb_d;
  int tb_depth = lrelu_params_pkg::DEPTH_3X3;
  int tb_ptr = 0;

  // next load staged before sending
  lrelu_stream_pkg::coef_t new_a [lrelu_params_pkg::GROUPS][lrelu_params_pkg::DEPTH_1X1];
  lrelu_stream_pkg::coef_t new_b [lrelu_params_pkg::GROUPS][lrelu_params_pkg::DEPTH_1X1];
  lrelu_stream_pkg::coef_t [lrelu_params_pkg::GROUPS-1:0] new_d;

  lrelu_stream_pkg::out_beat_t exp_q [$];
  int cyc_q [$];
  int cyc = 0;
  logic lat_check = 1'b0;
  logic bp_on = 1'b0;

  lrelu_engine dut_i (
    .clk       (clk),
    .rst       (rst),
    .cfg_valid (cfg_valid),
    .cfg_ready (cfg_ready),
    .cfg       (cfg),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_data    (s_data),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // random back-pressure when enabled
  always @(negedge clk) m_ready = bp_on ? 1'($urandom) : 1'b1;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  // scale, bias, leaky slope, offset, clamp
  function automatic lrelu_stream_pkg::out_t lrelu_ref(input lrelu_stream_pkg::acc_t x,
                                                       input lrelu_stream_pkg::coef_t a,
                                                       input lrelu_stream_pkg::coef_t b,
                                                       input lrelu_stream_pkg::coef_t d,
                                                       input logic flag);
    longint y;
    y = (longint'(x) * longint'(a)) >>> lrelu_params_pkg::SCALE_SHIFT;
    y = y + longint'(b);
    if (flag && y < 0) begin
      y = (y * lrelu_params_pkg::ALPHA_NUM) >>> lrelu_params_pkg::ALPHA_SHIFT;
    end
    y = y + longint'(d);
    if (y > 127) y = 127;
    if (y < -128) y = -128;
    return lrelu_stream_pkg::out_t'(y);
  endfunction

  function automatic lrelu_stream_pkg::out_beat_t expect_beat(
      input lrelu_stream_pkg::data_beat_t in);
    lrelu_stream_pkg::out_beat_t e;
    for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
      for (int u = 0; u < lrelu_params_pkg::UNITS; u++) begin
        e.lane[g][u] = lrelu_ref(in.lane[g][u], tb_a[g][tb_ptr], tb_b[g][tb_ptr],
                                 tb_d[g], in.is_lrelu);
      end
    end
    e.is_lrelu = in.is_lrelu;
    return e;
  endfunction

  task automatic check_out_beat(input lrelu_stream_pkg::out_beat_t got,
                                input lrelu_stream_pkg::out_beat_t exp);
    for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
      for (int u = 0; u < lrelu_params_pkg::UNITS; u++) begin
        if (got.lane[g][u] !== exp.lane[g][u]) begin
          fail_run($sformatf("MISMATCH at %0t: group %0d lane %0d got %0d expected %0d",
                             $time, g, u, got.lane[g][u], exp.lane[g][u]));
        end
      end
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_latency(input int got);
    if (got != 3) begin
      fail_run($sformatf("MISMATCH at %0t: latency %0d cycles, expected 3", $time, got));
    end
  endtask

  // expected results taken at each input handshake
  always @(posedge clk) begin
    if (!rst && s_valid && s_ready) begin
      exp_q.push_back(expect_beat(s_data));
      cyc_q.push_back(cyc);
      tb_ptr = (tb_ptr == tb_depth - 1) ? 0 : tb_ptr + 1;
    end
  end

  always @(posedge clk) begin : compare_outputs
    lrelu_stream_pkg::out_beat_t exp_beat;
    int in_cyc;
    if (!rst && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        fail_run("output beat arrived while none was expected");
      end else begin
        exp_beat = exp_q.pop_front();
        in_cyc = cyc_q.pop_front();
        check_out_beat(m_data, exp_beat);
        check_flag(m_data.is_lrelu, exp_beat.is_lrelu, "is_lrelu");
        if (lat_check) check_latency(cyc - in_cyc);
      end
    end
  end

  // entered and left on a falling edge
  task automatic send_cfg(input lrelu_stream_pkg::cfg_beat_t beat);
    int waited;
    logic done;
    waited = 0;
    done = 1'b0;
    cfg = beat;
    cfg_valid = 1'b1;
    while (!done) begin
      @(posedge clk);
      if (cfg_ready) begin
        done = 1'b1;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) fail_run("timeout: cfg_ready stayed low");
      end
    end
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  task automatic send_data(input lrelu_stream_pkg::data_beat_t beat);
    int waited;
    logic done;
    waited = 0;
    done = 1'b0;
    s_data = beat;
    s_valid = 1'b1;
    while (!done) begin
      @(posedge clk);
      if (s_ready) begin
        done = 1'b1;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) fail_run("timeout: s_ready stayed low");
      end
    end
    @(negedge clk);
    s_valid = 1'b0;
  endtask

  // D beat followed by the A and B tables
  task automatic load_tables(input lrelu_stream_pkg::kernel_mode_e mode, input logic gate_check);
    int depth;
    lrelu_stream_pkg::cfg_beat_t beat;
    depth = (mode == lrelu_stream_pkg::MODE_1X1) ? lrelu_params_pkg::DEPTH_1X1 :
                                                   lrelu_params_pkg::DEPTH_3X3;
    beat.mode = mode;
    beat.word = new_d;
    send_cfg(beat);
    tb_d = new_d;
    for (int k = 0; k < depth; k++) begin
      for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) beat.word[g] = new_a[g][k];
      send_cfg(beat);
      for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) tb_a[g][k] = new_a[g][k];
    end
    for (int k = 0; k < depth; k++) begin
      if (gate_check && k == depth - 1) begin
        @(posedge clk);
        check_flag(s_ready, 1'b0, "s_ready before last B beat");
        @(negedge clk);
      end
      for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) beat.word[g] = new_b[g][k];
      send_cfg(beat);
      for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) tb_b[g][k] = new_b[g][k];
    end
    tb_depth = depth;
    tb_ptr = 0;
  endtask

  task automatic fill_random_coefs();
    for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
      for (int k = 0; k < lrelu_params_pkg::DEPTH_1X1; k++) begin
        new_a[g][k] = lrelu_stream_pkg::coef_t'(int'($urandom_range(512)) - 128);
        new_b[g][k] = lrelu_stream_pkg::coef_t'(int'($urandom_range(200)) - 100);
      end
      new_d[g] = lrelu_stream_pkg::coef_t'(int'($urandom_range(40)) - 20);
    end
  endtask

  function automatic lrelu_stream_pkg::data_beat_t random_beat(input int span);
    lrelu_stream_pkg::data_beat_t b;
    for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
      for (int u = 0; u < lrelu_params_pkg::UNITS; u++) begin
        b.lane[g][u] = lrelu_stream_pkg::acc_t'(int'($urandom_range(2 * span)) - span);
      end
    end
    b.is_lrelu = 1'($urandom);
    return b;
  endfunction

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) fail_run("timeout: output beats still missing");
    end
  endtask

  initial begin : main_seq
    lrelu_stream_pkg::data_beat_t beat;
    void'($urandom(46617));
    rst = 1'b1;
    cfg_valid = 1'b0;
    cfg = '0;
    s_valid = 1'b0;
    s_data = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    check_flag(m_valid, 1'b0, "m_valid after reset");
    check_flag(cfg_ready, 1'b1, "cfg_ready after reset");
    check_flag(s_ready, 1'b0, "s_ready after reset");
    @(negedge clk);

    // 3x3 load of five beats and then data back to back
    fill_random_coefs();
    load_tables(lrelu_stream_pkg::MODE_3X3, 1'b1);
    @(posedge clk);
    check_flag(s_ready, 1'b1, "s_ready after 3x3 load");
    @(negedge clk);
    lat_check = 1'b1;
    for (int i = 0; i < 24; i++) send_data(random_beat(1500));
    wait_drain();

    // 1x1 reload where the pointer wraps at 6
    fill_random_coefs();
    load_tables(lrelu_stream_pkg::MODE_1X1, 1'b0);
    for (int i = 0; i < 30; i++) begin
      if ($urandom_range(3) == 0) @(negedge clk);
      send_data(random_beat(1500));
    end
    wait_drain();

    // directed negative sums and extremes
    for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
      for (int k = 0; k < lrelu_params_pkg::DEPTH_1X1; k++) begin
        new_a[g][k] = lrelu_stream_pkg::coef_t'(64 << (k + 2 * g));
        new_b[g][k] = lrelu_stream_pkg::coef_t'(5 * k - 10);
      end
      new_d[g] = lrelu_stream_pkg::coef_t'(4 * g - 2);
    end
    load_tables(lrelu_stream_pkg::MODE_3X3, 1'b0);
    for (int f = 1; f >= 0; f--) begin
      for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
        for (int u = 0; u < lrelu_params_pkg::UNITS; u++) begin
          beat.lane[g][u] = lrelu_stream_pkg::acc_t'(-150 * (u + 1) * (g + 1));
        end
      end
      beat.is_lrelu = 1'(f);
      send_data(beat);
    end
    for (int f = 0; f < 2; f++) begin
      for (int g = 0; g < lrelu_params_pkg::GROUPS; g++) begin
        for (int u = 0; u < lrelu_params_pkg::UNITS; u++) begin
          beat.lane[g][u] = (u % 2 == 0) ? lrelu_stream_pkg::acc_t'(32767) :
                                           lrelu_stream_pkg::acc_t'(-32768);
        end
      end
      beat.is_lrelu = 1'(f);
      send_data(beat);
    end
    wait_drain();

    // random back-pressure
    lat_check = 1'b0;
    bp_on = 1'b1;
    fill_random_coefs();
    load_tables(lrelu_stream_pkg::MODE_1X1, 1'b0);
    for (int i = 0; i < 40; i++) begin
      if ($urandom_range(3) == 0) @(negedge clk);
      send_data(random_beat(3000));
    end
    wait_drain();
    bp_on = 1'b0;

    // idle cycles so a stray output beat still reaches the compare process
    repeat (5) @(negedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== lrelu_engine.f ====
lrelu_params_pkg.sv
lrelu_stream_pkg.sv
lrelu_coef_store.sv
lrelu_lane_math.sv
lrelu_requant.sv
lrelu_engine.sv
lrelu_engine_asserts.sv
lrelu_engine_tb.sv

// ==== Makefile ====
TOP = lrelu_engine_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f lrelu_engine.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@grep -q "All tests passed" sim.log && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log
